//--- lfr_config.svh
`ifndef LFR_CONFIG_SVH
`define LFR_CONFIG_SVH

////////////////////
// Port geometry

// Number of ingress ports sharing the buffer
`define LFR_NUM_PORTS 4
// Width of a port index
`define LFR_PORT_BITS 2

////////////////////
// Memory geometry

// Per-port pointer width, memory address is {port, pointer}
`define LFR_PTR_BITS 8
// Bytes carried by one memory word
`define LFR_WORD_BYTES 8
// Frame length field, low bits of the header word
`define LFR_LEN_BITS 11

////////////////////
// Read tracking

// Must be larger than the worst memory latency in cycles
`define LFR_TAG_DEPTH 8

`endif

//--- lfr_pkg.sv
`include "lfr_config.svh"

package lfr_pkg;

	// Frame-level reader states
	typedef enum logic [1:0] {
		READER_IDLE,
		READER_HEADER_WAIT,
		READER_PAYLOAD,
		READER_DRAIN
	} reader_state_t;

	// Why a memory read was issued
	typedef enum logic {
		TAG_HEADER,
		TAG_PAYLOAD
	} read_tag_t;

	// One memory word, also one output beat
	typedef logic [`LFR_WORD_BYTES*8-1:0] data_word_t;
	typedef logic [`LFR_PTR_BITS-1:0] port_ptr_t;
	typedef logic [`LFR_PORT_BITS-1:0] port_idx_t;
	// Frame length in bytes
	typedef logic [`LFR_LEN_BITS-1:0] frame_len_t;

endpackage

//--- frame_reader_fsm.sv
`include "lfr_config.svh"

module frame_reader_fsm (
	input	logic				clk,
	input	logic				rst_n,
	input	logic [`LFR_NUM_PORTS-1:0]	pending,
	input	lfr_pkg::port_idx_t		rr_port,
	input	logic				xbar_ready,
	input	lfr_pkg::read_tag_t		head_tag,
	input	logic				rd_valid,
	input	logic				bytes_to_read_zero,
	input	logic				last_word,
	output	logic				rd_en,
	output	lfr_pkg::read_tag_t		rd_tag,
	output	lfr_pkg::port_idx_t		cur_port,
	output	logic				load_len,
	output	logic				advance_rr,
	output	logic				read_step
);

	lfr_pkg::reader_state_t state;
	lfr_pkg::reader_state_t state_next;
	// Port owning the frame in flight
	lfr_pkg::port_idx_t claimed_port;
	logic claim;
	logic header_ret;
	logic frame_done;

	////////////////////
	// Decode of returns and claim

	always_comb begin
		// Xbar readiness only matters at the moment a port is claimed
		claim = (state == lfr_pkg::READER_IDLE) && pending[rr_port] && xbar_ready;
		header_ret = rd_valid && (head_tag == lfr_pkg::TAG_HEADER);
		// Final payload word coming back from memory
		frame_done = rd_valid && (head_tag == lfr_pkg::TAG_PAYLOAD) && last_word;
	end

	////////////////////
	// Next state and read issue

	always_comb begin
		state_next = state;
		rd_en = 1'b0;
		rd_tag = lfr_pkg::TAG_PAYLOAD;
		load_len = 1'b0;
		read_step = 1'b0;
		case (state)
			lfr_pkg::READER_IDLE: begin
				// Header read goes out in the claim cycle
				if (claim) begin
					rd_en = 1'b1;
					rd_tag = lfr_pkg::TAG_HEADER;
					state_next = lfr_pkg::READER_HEADER_WAIT;
				end
			end
			lfr_pkg::READER_HEADER_WAIT: begin
				// Only the header is outstanding here
				if (header_ret) begin
					load_len = 1'b1;
					state_next = lfr_pkg::READER_PAYLOAD;
				end
			end
			lfr_pkg::READER_PAYLOAD: begin
				// Short latency can land the last word before drain
				if (frame_done) begin
					state_next = lfr_pkg::READER_IDLE;
				end else if (bytes_to_read_zero) begin
					state_next = lfr_pkg::READER_DRAIN;
				end else begin
					rd_en = 1'b1;
					read_step = 1'b1;
				end
			end
			lfr_pkg::READER_DRAIN: begin
				// All reads issued, wait for the tail to come back
				if (frame_done)
					state_next = lfr_pkg::READER_IDLE;
			end
			default: state_next = lfr_pkg::READER_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= lfr_pkg::READER_IDLE;
			claimed_port <= '0;
		end else begin
			state <= state_next;
			if (claim)
				claimed_port <= rr_port;
		end
	end

	// Scan keeps moving while idle, so after a frame it sits one port past the winner
	assign advance_rr = (state == lfr_pkg::READER_IDLE);
	// Scan position while idle, owner otherwise
	assign cur_port = (state == lfr_pkg::READER_IDLE) ? rr_port : claimed_port;

endmodule

//--- frame_byte_counter.sv
`include "lfr_config.svh"

module frame_byte_counter (
	input	logic			clk,
	input	logic			rst_n,
	input	logic			advance_rr,
	input	logic			load_len,
	input	lfr_pkg::frame_len_t	len,
	input	logic			read_step,
	input	logic			send_step,
	output	lfr_pkg::port_idx_t	rr_port,
	output	logic			bytes_to_read_zero,
	output	lfr_pkg::frame_len_t	bytes_to_send,
	output	logic			last_word
);

	localparam lfr_pkg::port_idx_t LAST_PORT = lfr_pkg::port_idx_t'(`LFR_NUM_PORTS - 1);
	localparam lfr_pkg::frame_len_t WORD = lfr_pkg::frame_len_t'(`LFR_WORD_BYTES);

	// Bytes not yet requested from memory
	lfr_pkg::frame_len_t bytes_to_read;

	// One word less, never below zero
	function automatic lfr_pkg::frame_len_t step_down(input lfr_pkg::frame_len_t cnt);
		return (cnt > WORD) ? cnt - WORD : '0;
	endfunction

	////////////////////
	// Round-robin scan

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rr_port <= '0;
		else if (advance_rr)
			rr_port <= (rr_port == LAST_PORT) ? '0 : rr_port + 1'b1;
	end

	////////////////////
	// Byte counters of the current frame

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bytes_to_read <= '0;
			bytes_to_send <= '0;
		end else if (load_len) begin
			// Both start from the header length
			bytes_to_read <= len;
			bytes_to_send <= len;
		end else begin
			if (read_step)
				bytes_to_read <= step_down(bytes_to_read);
			if (send_step)
				bytes_to_send <= step_down(bytes_to_send);
		end
	end

	assign bytes_to_read_zero = (bytes_to_read == '0);
	// Word in delivery is the tail
	assign last_word = (bytes_to_send <= WORD);

endmodule

//--- read_tag_fifo.sv
`include "lfr_config.svh"

module read_tag_fifo (
	input	logic			clk,
	input	logic			rst_n,
	input	logic			push,
	input	lfr_pkg::read_tag_t	push_tag,
	input	logic			pop,
	output	lfr_pkg::read_tag_t	head_tag
);

	localparam int unsigned AW = $clog2(`LFR_TAG_DEPTH);
	localparam logic [AW-1:0] LAST_SLOT = AW'(`LFR_TAG_DEPTH - 1);

	// One tag per outstanding read, oldest at rd_idx
	lfr_pkg::read_tag_t tags [`LFR_TAG_DEPTH];
	logic [AW-1:0] wr_idx;
	logic [AW-1:0] rd_idx;

	// Circular step, also safe for depths that are not a power of two
	function automatic logic [AW-1:0] next_slot(input logic [AW-1:0] idx);
		return (idx == LAST_SLOT) ? '0 : idx + 1'b1;
	endfunction

	////////////////////
	// Tag storage

	always_ff @(posedge clk) begin
		if (push)
			tags[wr_idx] <= push_tag;
	end

	////////////////////
	// Pointers

	// Memory returns in request order, so a pop always matches the head
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_idx <= '0;
			rd_idx <= '0;
		end else begin
			if (push)
				wr_idx <= next_slot(wr_idx);
			if (pop)
				rd_idx <= next_slot(rd_idx);
		end
	end

	// Tag of the read whose data comes back next
	assign head_tag = tags[rd_idx];

endmodule

//--- port_read_pointers.sv
`include "lfr_config.svh"

module port_read_pointers (
	input	logic				clk,
	input	logic				rst_n,
	input	lfr_pkg::port_ptr_t		wr_ptr_committed [`LFR_NUM_PORTS],
	input	logic				inc,
	input	lfr_pkg::port_idx_t		inc_port,
	output	lfr_pkg::port_ptr_t		rd_ptr [`LFR_NUM_PORTS],
	output	logic [`LFR_NUM_PORTS-1:0]	pending
);

	////////////////////
	// Read pointers

	// One step per word read, header included
	// Writer sees the freed space through rd_ptr
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LFR_NUM_PORTS; i++)
				rd_ptr[i] <= '0;
		end else if (inc) begin
			// Wraps naturally at the port's region size
			rd_ptr[inc_port] <= rd_ptr[inc_port] + 1'b1;
		end
	end

	////////////////////
	// Work flags

	// Any committed word not yet read means a frame is waiting
	always_comb begin
		for (int i = 0; i < `LFR_NUM_PORTS; i++)
			pending[i] = (wr_ptr_committed[i] != rd_ptr[i]);
	end

endmodule

//--- tx_word_formatter.sv
`include "lfr_config.svh"

module tx_word_formatter (
	input	logic				clk,
	input	logic				rst_n,
	input	logic				rd_valid,
	input	lfr_pkg::read_tag_t		head_tag,
	input	lfr_pkg::data_word_t		rd_data,
	input	lfr_pkg::frame_len_t		bytes_to_send,
	input	logic				last_word,
	input	lfr_pkg::port_idx_t		cur_port,
	output	logic				send_step,
	output	logic				tx_valid,
	output	lfr_pkg::data_word_t		tx_data,
	output	logic [`LFR_WORD_BYTES-1:0]	tx_strb,
	output	logic				tx_last,
	output	lfr_pkg::port_idx_t		tx_port
);

	localparam int unsigned LANE_BITS = $clog2(`LFR_WORD_BYTES);

	logic [`LFR_WORD_BYTES-1:0] strb_next;

	// Payload word arriving from memory this cycle
	assign send_step = rd_valid && (head_tag == lfr_pkg::TAG_PAYLOAD);

	// Full lanes except on a short tail word
	always_comb begin
		strb_next = '1;
		if (last_word && (bytes_to_send < `LFR_WORD_BYTES))
			strb_next = ~({`LFR_WORD_BYTES{1'b1}} << bytes_to_send[LANE_BITS-1:0]);
	end

	////////////////////
	// Output stage, one cycle behind rd_valid

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_valid <= 1'b0;
			tx_last <= 1'b0;
		end else begin
			tx_valid <= send_step;
			tx_last <= send_step && last_word;
		end
	end

	always_ff @(posedge clk) begin
		if (send_step) begin
			tx_data <= rd_data;
			tx_strb <= strb_next;
			tx_port <= cur_port;
		end
	end

endmodule

//--- line_fifo_reader.sv
`include "lfr_config.svh"

module line_fifo_reader (
	input	logic					clk,
	input	logic					rst_n,
	input	lfr_pkg::port_ptr_t			wr_ptr_committed [`LFR_NUM_PORTS],
	output	lfr_pkg::port_ptr_t			rd_ptr [`LFR_NUM_PORTS],
	output	logic					rd_en,
	output	logic [`LFR_PORT_BITS+`LFR_PTR_BITS-1:0]	rd_addr,
	input	lfr_pkg::data_word_t			rd_data,
	input	logic					rd_valid,
	input	logic					xbar_ready,
	output	logic					tx_valid,
	output	lfr_pkg::data_word_t			tx_data,
	output	logic [`LFR_WORD_BYTES-1:0]		tx_strb,
	output	logic					tx_last,
	output	lfr_pkg::port_idx_t			tx_port
);

	logic [`LFR_NUM_PORTS-1:0] pending;
	lfr_pkg::port_idx_t rr_port;
	lfr_pkg::port_idx_t cur_port;
	lfr_pkg::read_tag_t rd_tag;
	lfr_pkg::read_tag_t head_tag;
	lfr_pkg::frame_len_t hdr_len;
	lfr_pkg::frame_len_t bytes_to_send;
	logic bytes_to_read_zero;
	logic last_word;
	logic load_len;
	logic advance_rr;
	logic read_step;
	logic send_step;

	////////////////////
	// Address and header decode

	// Each port owns a contiguous region indexed by its pointer
	assign rd_addr = {cur_port, rd_ptr[cur_port]};
	// Length field of a header word
	assign hdr_len = rd_data[`LFR_LEN_BITS-1:0];

	////////////////////
	// Reader blocks

	frame_reader_fsm i_frame_reader_fsm (
		.clk(clk), .rst_n(rst_n), .pending(pending), .rr_port(rr_port),
		.xbar_ready(xbar_ready), .head_tag(head_tag), .rd_valid(rd_valid),
		.bytes_to_read_zero(bytes_to_read_zero), .last_word(last_word),
		.rd_en(rd_en), .rd_tag(rd_tag), .cur_port(cur_port), .load_len(load_len),
		.advance_rr(advance_rr), .read_step(read_step)
	);

	frame_byte_counter i_frame_byte_counter (
		.clk(clk), .rst_n(rst_n), .advance_rr(advance_rr), .load_len(load_len),
		.len(hdr_len), .read_step(read_step), .send_step(send_step), .rr_port(rr_port),
		.bytes_to_read_zero(bytes_to_read_zero), .bytes_to_send(bytes_to_send),
		.last_word(last_word)
	);

	// Tags follow the reads in flight, popped as data returns
	read_tag_fifo i_read_tag_fifo (
		.clk(clk), .rst_n(rst_n), .push(rd_en), .push_tag(rd_tag), .pop(rd_valid),
		.head_tag(head_tag)
	);

	port_read_pointers i_port_read_pointers (
		.clk(clk), .rst_n(rst_n), .wr_ptr_committed(wr_ptr_committed), .inc(rd_en),
		.inc_port(cur_port), .rd_ptr(rd_ptr), .pending(pending)
	);

	tx_word_formatter i_tx_word_formatter (
		.clk(clk), .rst_n(rst_n), .rd_valid(rd_valid), .head_tag(head_tag),
		.rd_data(rd_data), .bytes_to_send(bytes_to_send), .last_word(last_word),
		.cur_port(cur_port), .send_step(send_step), .tx_valid(tx_valid),
		.tx_data(tx_data), .tx_strb(tx_strb), .tx_last(tx_last), .tx_port(tx_port)
	);

endmodule

//--- line_fifo_reader_assert.sv
`include "lfr_config.svh"

module line_fifo_reader_assert (
	input	logic				clk,
	input	logic				rst_n,
	input	logic				rd_en,
	input	logic				tx_valid,
	input	logic				tx_last,
	input	logic [`LFR_WORD_BYTES-1:0]	tx_strb
);

	timeunit 1ns;
	timeprecision 100ps;

	// Failures seen by the properties, read back by the testbench
	int assert_errors = 0;

	////////////////////
	// Output stream rules

	// End of frame only on a real beat
	last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n) tx_last |-> tx_valid)
		else begin
			assert_errors++;
			$error("tx_last high without tx_valid");
		end

	// Every beat carries at least one byte
	strb_nonzero: assert property (@(posedge clk) disable iff (!rst_n) tx_valid |-> tx_strb != '0)
		else begin
			assert_errors++;
			$error("tx_strb empty on a valid beat");
		end

	////////////////////
	// Memory side

	// No memory reads while held in reset
	quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !rd_en)
		else begin
			assert_errors++;
			$error("rd_en high during reset");
		end

endmodule

bind line_fifo_reader line_fifo_reader_assert i_line_fifo_reader_assert (
	.clk(clk), .rst_n(rst_n), .rd_en(rd_en), .tx_valid(tx_valid), .tx_last(tx_last),
	.tx_strb(tx_strb)
);

//--- line_fifo_reader_tb.sv
`include "lfr_config.svh"

module line_fifo_reader_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_FRAMES = 9;
	localparam int NUM_BATCHES = 6;
	localparam int MEM_WORDS = 1 << (`LFR_PORT_BITS + `LFR_PTR_BITS);

	logic clk;
	logic rst_n;
	lfr_pkg::port_ptr_t wr_ptr_committed [`LFR_NUM_PORTS];
	lfr_pkg::port_ptr_t rd_ptr [`LFR_NUM_PORTS];
	logic rd_en;
	logic [`LFR_PORT_BITS+`LFR_PTR_BITS-1:0] rd_addr;
	lfr_pkg::data_word_t rd_data;
	logic rd_valid;
	logic xbar_ready;
	logic tx_valid;
	lfr_pkg::data_word_t tx_data;
	logic [`LFR_WORD_BYTES-1:0] tx_strb;
	logic tx_last;
	lfr_pkg::port_idx_t tx_port;

	// Frame table columns are port, length in bytes, batch and cycles with xbar_ready low
	int tbl_port [NUM_FRAMES];
	int tbl_len [NUM_FRAMES];
	int tbl_batch [NUM_FRAMES];
	int tbl_hold [NUM_FRAMES];
	// Header pointer of each frame as laid out by the preload
	int frame_start [NUM_FRAMES];
	bit frame_done [NUM_FRAMES];

	// Buffer memory model and its two-stage return pipe
	lfr_pkg::data_word_t mem [MEM_WORDS];
	logic req_v1 = 1'b0;
	logic req_v2 = 1'b0;
	logic [`LFR_PORT_BITS+`LFR_PTR_BITS-1:0] req_a1;
	logic [`LFR_PORT_BITS+`LFR_PTR_BITS-1:0] req_a2;

	integer seed = 66;
	int errors = 0;
	int frames_seen = 0;
	int words_seen = 0;
	int cycles = 0;
	int cycle_limit = 0;

	line_fifo_reader i_line_fifo_reader (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////
	// Memory model

	// Request taken at the rising edge and data back two cycles later
	always @(posedge clk) begin
		req_v2 <= req_v1;
		req_a2 <= req_a1;
		req_v1 <= rd_en;
		req_a1 <= rd_addr;
	end

	always @(negedge clk) begin
		rd_valid <= req_v2;
		rd_data <= req_v2 ? mem[req_a2] : '0;
	end

	// Run limit from the table size
	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout after %0d cycles with frames still undelivered", cycles);
			$display("Frames %0d, words %0d, errors %0d", frames_seen, words_seen, errors);
			$display("Checks failed");
			$finish;
		end
	end

	////////////////////
	// Helpers

	task automatic set_entry(input int idx, input int port, input int len, input int batch,
		input int hold);
		tbl_port[idx] = port;
		tbl_len[idx] = len;
		tbl_batch[idx] = batch;
		tbl_hold[idx] = hold;
	endtask

	// Payload words with the length rounded up to whole words
	function automatic int word_count(input int len);
		return (len + `LFR_WORD_BYTES - 1) / `LFR_WORD_BYTES;
	endfunction

	function automatic int mem_index(input int port, input int ptr);
		return (port << `LFR_PTR_BITS) + (ptr % (1 << `LFR_PTR_BITS));
	endfunction

	// Low lanes of a short tail and all lanes on a full one
	function automatic logic [`LFR_WORD_BYTES-1:0] tail_strobe(input int len);
		int rem;
		rem = len % `LFR_WORD_BYTES;
		if (rem == 0)
			return '1;
		return (1 << rem) - 1;
	endfunction

	// Oldest undelivered frame of a port in this batch
	function automatic int pending_entry(input int port, input int batch);
		for (int e = 0; e < NUM_FRAMES; e++)
			if (tbl_batch[e] == batch && tbl_port[e] == port && !frame_done[e])
				return e;
		return -1;
	endfunction

	// First port with work after the last one served
	function automatic int next_port_after(input int last, input int batch);
		int p;
		for (int k = 1; k <= `LFR_NUM_PORTS; k++) begin
			p = (last + k) % `LFR_NUM_PORTS;
			if (pending_entry(p, batch) >= 0)
				return p;
		end
		return -1;
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] got,
		input logic [63:0] want);
		errors++;
		$display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, want);
	endtask

	// Address-dependent fill and then header and random payload per frame
	task automatic preload_memory();
		int wp [`LFR_NUM_PORTS];
		for (int a = 0; a < MEM_WORDS; a++)
			mem[a] = 64'hbad0_0000_0000_0000 | a;
		for (int p = 0; p < `LFR_NUM_PORTS; p++)
			wp[p] = 0;
		for (int e = 0; e < NUM_FRAMES; e++) begin
			frame_start[e] = wp[tbl_port[e]];
			mem[mem_index(tbl_port[e], wp[tbl_port[e]])] = tbl_len[e];
			wp[tbl_port[e]]++;
			for (int w = 0; w < word_count(tbl_len[e]); w++) begin
				mem[mem_index(tbl_port[e], wp[tbl_port[e]])] = {$random(seed), $random(seed)};
				wp[tbl_port[e]]++;
			end
		end
	endtask

	// One received beat against the stored frame
	task automatic check_word(input int e, input int idx);
		lfr_pkg::data_word_t want;
		logic is_last;
		want = mem[mem_index(tbl_port[e], frame_start[e] + 1 + idx)];
		is_last = (idx == word_count(tbl_len[e]) - 1);
		if (tx_data !== want)
			report_mismatch("tx_data", tx_data, want);
		if (tx_port !== lfr_pkg::port_idx_t'(tbl_port[e]))
			report_mismatch("tx_port", tx_port, tbl_port[e]);
		if (tx_last !== is_last)
			report_mismatch("tx_last", tx_last, is_last);
		if (tx_strb !== (is_last ? tail_strobe(tbl_len[e]) : '1))
			report_mismatch("tx_strb", tx_strb, is_last ? tail_strobe(tbl_len[e]) : '1);
		words_seen++;
	endtask

	// Commit one batch and collect its frames
	task automatic run_batch(input int b);
		int count;
		int hold;
		int served;
		int last_port;
		int cur;
		int idx;
		count = 0;
		hold = 0;
		served = 0;
		last_port = -1;
		cur = -1;
		idx = 0;
		for (int e = 0; e < NUM_FRAMES; e++) begin
			if (tbl_batch[e] == b) begin
				count++;
				hold = (tbl_hold[e] > hold) ? tbl_hold[e] : hold;
				wr_ptr_committed[tbl_port[e]] = lfr_pkg::port_ptr_t'(frame_start[e] + 1 +
					word_count(tbl_len[e]));
			end
		end
		// Nothing may leave while the crossbar is busy
		if (hold > 0) begin
			xbar_ready = 1'b0;
			repeat (hold) begin
				@(negedge clk);
				if (tx_valid !== 1'b0)
					report_mismatch("tx_valid with xbar_ready low", tx_valid, 0);
			end
			xbar_ready = 1'b1;
		end
		while (served < count) begin
			@(negedge clk);
			if (tx_valid === 1'b1) begin
				if (cur < 0) begin
					cur = pending_entry(tx_port, b);
					if (cur < 0) begin
						errors++;
						$display("Frame started on port %0d, which had no frame waiting", tx_port);
					end else if (last_port >= 0 && tx_port !== next_port_after(last_port, b)) begin
						report_mismatch("round-robin port", tx_port, next_port_after(last_port, b));
					end
				end
				if (cur >= 0) begin
					check_word(cur, idx);
					idx++;
					if (idx == word_count(tbl_len[cur])) begin
						frame_done[cur] = 1'b1;
						served++;
						frames_seen++;
						last_port = tbl_port[cur];
						cur = -1;
						idx = 0;
					end
				end
			end
		end
	endtask

	////////////////////
	// Stimulus

	initial begin
		int total;
		rst_n = 1'b0;
		xbar_ready = 1'b0;
		rd_valid = 1'b0;
		rd_data = '0;
		for (int p = 0; p < `LFR_NUM_PORTS; p++)
			wr_ptr_committed[p] = '0;
		// Single frames first
		// Then three ports at once with a second frame queued on port 2
		// Then a busy crossbar
		set_entry(0, 0, 1, 0, 0);
		set_entry(1, 1, 8, 1, 0);
		set_entry(2, 2, 13, 2, 0);
		set_entry(3, 3, 64, 3, 0);
		set_entry(4, 2, 20, 4, 0);
		set_entry(5, 2, 5, 4, 0);
		set_entry(6, 3, 16, 4, 0);
		set_entry(7, 1, 9, 4, 0);
		set_entry(8, 1, 24, 5, 12);
		preload_memory();
		total = 0;
		for (int e = 0; e < NUM_FRAMES; e++)
			total += 1 + word_count(tbl_len[e]) + tbl_hold[e];
		cycle_limit = 20 * total + 20;

		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		xbar_ready = 1'b1;
		// Quiet after reset with nothing committed
		repeat (4) begin
			@(negedge clk);
			if (tx_valid !== 1'b0)
				report_mismatch("tx_valid after reset", tx_valid, 0);
			if (tx_last !== 1'b0)
				report_mismatch("tx_last after reset", tx_last, 0);
			if (rd_en !== 1'b0)
				report_mismatch("rd_en after reset", rd_en, 0);
			for (int p = 0; p < `LFR_NUM_PORTS; p++)
				if (rd_ptr[p] !== '0)
					report_mismatch("rd_ptr after reset", rd_ptr[p], 0);
		end

		for (int b = 0; b < NUM_BATCHES; b++)
			run_batch(b);

		// Every committed word consumed
		repeat (4) @(negedge clk);
		for (int p = 0; p < `LFR_NUM_PORTS; p++)
			if (rd_ptr[p] !== wr_ptr_committed[p])
				report_mismatch("final rd_ptr", rd_ptr[p], wr_ptr_committed[p]);

		errors += i_line_fifo_reader.i_line_fifo_reader_assert.assert_errors;
		$display("Frames %0d, words %0d, errors %0d", frames_seen, words_seen, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- build.f
+incdir+.
lfr_pkg.sv
frame_reader_fsm.sv
frame_byte_counter.sv
read_tag_fifo.sv
port_read_pointers.sv
tx_word_formatter.sv
line_fifo_reader.sv
line_fifo_reader_assert.sv
line_fifo_reader_tb.sv
